/* source/mem_cfg_pkg.sv */
package mem_cfg_pkg;

  //////////////////////////////
  // Data path sizing
  //////////////////////////////

  // Data word width
  localparam int XLEN = 32;

  // Byte lanes per word, one bank each
  localparam int LANES = 4;

  // Register number width
  localparam int REG_W = 5;

  //////////////////////////////
  // Data memory sizing
  //////////////////////////////

  // Words held by each bank
  localparam int DEPTH_WORDS = 256;

  // Bank index width, taken from alu_res above the byte offset
  localparam int INDEX_W = 8;

endpackage : mem_cfg_pkg

/* source/mem_stage_pkg.sv */
package mem_stage_pkg;

  //////////////////////////////
  // Memory operation encoding
  //////////////////////////////

  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB   = 4'd1,
    MEM_LH   = 4'd2,
    MEM_LW   = 4'd3,
    MEM_LBU  = 4'd4,
    MEM_LHU  = 4'd5,
    MEM_SB   = 4'd6,
    MEM_SH   = 4'd7,
    MEM_SW   = 4'd8
  } mem_op_e;

  // Op class helpers shared by the store and load sides
  function automatic logic is_load(mem_op_e op);
    return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
  endfunction

  function automatic logic is_store(mem_op_e op);
    return op inside {MEM_SB, MEM_SH, MEM_SW};
  endfunction

  //////////////////////////////
  // Pipeline register contents
  //////////////////////////////

  // EX/MEM register, alu_res is the address for memory ops
  typedef struct packed {
    mem_op_e                       op;
    logic [mem_cfg_pkg::XLEN-1:0]  alu_res;
    logic [mem_cfg_pkg::REG_W-1:0] rs2_num;
    logic [mem_cfg_pkg::XLEN-1:0]  rs2_data;
    logic [mem_cfg_pkg::REG_W-1:0] rd;
    logic                          regwrite;
  } ex_mem_t;

  // One byte-wide bank access
  typedef struct packed {
    logic                            en;
    logic                            we;
    logic [mem_cfg_pkg::INDEX_W-1:0] index;
    logic [7:0]                      wdata;
  } lane_req_t;

  // MEM/WB output, result is the final writeback value
  typedef struct packed {
    logic                          regwrite;
    logic [mem_cfg_pkg::REG_W-1:0] rd;
    logic                          memread;
    logic [mem_cfg_pkg::XLEN-1:0]  alu_res;
    logic [mem_cfg_pkg::XLEN-1:0]  result;
  } mem_wb_t;

endpackage : mem_stage_pkg

/* source/store_lane_unit.sv */
module store_lane_unit (
  input  logic                         bus,
  input  logic                         rst,
  input  mem_stage_pkg::ex_mem_t       ex_mem,
  input  logic                         hold,
  input  mem_stage_pkg::mem_wb_t       mem_wb,
  input  logic [mem_cfg_pkg::XLEN-1:0] wb_res,
  output mem_stage_pkg::lane_req_t     lane_req [mem_cfg_pkg::LANES]
);

  logic                            is_store;
  logic                            is_load;
  logic                            access;
  logic                            fwd;
  logic [mem_cfg_pkg::XLEN-1:0]    store_data;
  logic [1:0]                      offset;
  logic [1:0]                      rot;
  logic [mem_cfg_pkg::INDEX_W-1:0] bank_index;
  logic [mem_cfg_pkg::LANES-1:0]   lane_en;
  logic [mem_cfg_pkg::LANES-1:0]   lane_we;

  //////////////////////////////
  // Store hazard forwarding
  //////////////////////////////

  assign is_store = mem_stage_pkg::is_store(ex_mem.op);
  assign is_load  = mem_stage_pkg::is_load(ex_mem.op);

  // Previous instruction writes the register this store reads
  // x0 never forwards
  assign fwd = is_store && mem_wb.regwrite &&
               (mem_wb.rd == ex_mem.rs2_num) && (mem_wb.rd != '0);

  assign store_data = fwd ? wb_res : ex_mem.rs2_data;

  //////////////////////////////
  // Lane alignment
  //////////////////////////////

  assign offset     = ex_mem.alu_res[1:0];
  assign bank_index = ex_mem.alu_res[mem_cfg_pkg::INDEX_W+1:2];

  // Frozen stage or non-memory op touches no bank
  assign access = !hold && (ex_mem.op != mem_stage_pkg::MEM_NONE);

  // SW keeps byte order, SB and SH shift byte 0 up to the offset lane
  assign rot = (ex_mem.op == mem_stage_pkg::MEM_SW) ? 2'd0 : offset;

  for (genvar i = 0; i < mem_cfg_pkg::LANES; i++) begin : g_lane
    localparam logic [1:0] LANE_ID = 2'(i);

    logic       hit_byte;
    logic       hit_half;
    logic [1:0] src;

    assign hit_byte = (LANE_ID == offset);
    // Second half of SH wraps from lane 3 to lane 0
    assign hit_half = hit_byte || (LANE_ID == 2'(offset + 2'd1));

    // Byte of the store data that lands in this lane
    assign src = 2'(LANE_ID - rot);

    assign lane_en[i] = access &&
                        (is_load || (ex_mem.op == mem_stage_pkg::MEM_SW) ||
                         ((ex_mem.op == mem_stage_pkg::MEM_SB) && hit_byte) ||
                         ((ex_mem.op == mem_stage_pkg::MEM_SH) && hit_half));
    assign lane_we[i] = lane_en[i] && is_store;

    assign lane_req[i] = '{en: lane_en[i], we: lane_we[i], index: bank_index,
                           wdata: store_data[{src, 3'b000} +: 8]};
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Byte store reaches exactly one bank
  a_sb_one_lane : assert property (@(posedge bus) disable iff (rst)
    (ex_mem.op == mem_stage_pkg::MEM_SB && !hold) |-> $onehot(lane_we));

  // Frozen stage never writes memory
  a_hold_no_write : assert property (@(posedge bus) disable iff (rst)
    hold |-> (lane_we == '0));

endmodule : store_lane_unit

/* source/data_bank.sv */
module data_bank (
  input  logic                      bus,
  input  mem_stage_pkg::lane_req_t  req,
  output logic [7:0]                rdata
);

  //////////////////////////////
  // Byte-wide block RAM
  //////////////////////////////

  // One byte lane of every data word
  logic [7:0] mem [mem_cfg_pkg::DEPTH_WORDS];

  // Write port, only on an enabled write strobe
  always_ff @(posedge bus) begin
    if (req.en && req.we) begin
      mem[req.index] <= req.wdata;
    end
  end

  // Read port is read-first
  // A store sees the old byte, rdata holds while idle
  always_ff @(posedge bus) begin
    if (req.en) begin
      rdata <= mem[req.index];
    end
  end

endmodule : data_bank

/* source/load_writeback_unit.sv */
module load_writeback_unit (
  input  logic                   bus,
  input  logic                   rst,
  input  mem_stage_pkg::ex_mem_t ex_mem,
  input  logic                   hold,
  input  logic [7:0]             lane_rdata [mem_cfg_pkg::LANES],
  output mem_stage_pkg::mem_wb_t mem_wb
);

  mem_stage_pkg::mem_op_e        op_q;
  logic [1:0]                    offset_q;
  logic                          regwrite_q;
  logic                          memread_q;
  logic [mem_cfg_pkg::REG_W-1:0] rd_q;
  logic [mem_cfg_pkg::XLEN-1:0]  alu_res_q;
  logic [1:0]                    rot;
  logic [mem_cfg_pkg::XLEN-1:0]  load_word;
  logic [mem_cfg_pkg::XLEN-1:0]  result;

  //////////////////////////////
  // MEM/WB pipeline register
  //////////////////////////////

  // Captured on the same edge the banks complete their access
  always_ff @(posedge bus) begin
    if (rst) begin
      op_q       <= mem_stage_pkg::MEM_NONE;
      offset_q   <= 2'd0;
      regwrite_q <= 1'b0;
      memread_q  <= 1'b0;
      rd_q       <= '0;
      alu_res_q  <= '0;
    end else if (!hold) begin
      op_q       <= ex_mem.op;
      offset_q   <= ex_mem.alu_res[1:0];
      regwrite_q <= ex_mem.regwrite;
      memread_q  <= mem_stage_pkg::is_load(ex_mem.op);
      rd_q       <= ex_mem.rd;
      alu_res_q  <= ex_mem.alu_res;
    end
  end

  //////////////////////////////
  // Lane realignment
  //////////////////////////////

  // LW reads the lanes in plain byte order
  assign rot = (op_q == mem_stage_pkg::MEM_LW) ? 2'd0 : offset_q;

  // Byte k of the loaded value comes from lane (offset + k) mod 4
  // So a halfword at offset 3 takes lanes 3 and 0
  for (genvar k = 0; k < mem_cfg_pkg::LANES; k++) begin : g_byte
    localparam logic [1:0] BYTE_ID = 2'(k);

    logic [1:0] src;

    assign src                = 2'(BYTE_ID + rot);
    assign load_word[8*k +: 8] = lane_rdata[src];
  end

  //////////////////////////////
  // Load extension
  //////////////////////////////

  always_comb begin
    unique case (op_q)
      // Signed loads
      mem_stage_pkg::MEM_LB:
        result = {{(mem_cfg_pkg::XLEN-8){load_word[7]}}, load_word[7:0]};
      mem_stage_pkg::MEM_LH:
        result = {{(mem_cfg_pkg::XLEN-16){load_word[15]}}, load_word[15:0]};
      mem_stage_pkg::MEM_LW:
        result = load_word;
      // Unsigned loads
      mem_stage_pkg::MEM_LBU:
        result = {{(mem_cfg_pkg::XLEN-8){1'b0}}, load_word[7:0]};
      mem_stage_pkg::MEM_LHU:
        result = {{(mem_cfg_pkg::XLEN-16){1'b0}}, load_word[15:0]};
      // Stores and ALU ops write back the ALU result
      default:
        result = alu_res_q;
    endcase
  end

  assign mem_wb = '{regwrite: regwrite_q, rd: rd_q, memread: memread_q,
                    alu_res: alu_res_q, result: result};

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Load flag and registered op never disagree
  a_memread_is_load : assert property (@(posedge bus) disable iff (rst)
    mem_wb.memread |-> mem_stage_pkg::is_load(op_q));

endmodule : load_writeback_unit

/* source/mem_stage.sv */
module mem_stage (
  input  logic                         bus,
  input  logic                         rst,
  input  mem_stage_pkg::ex_mem_t       ex_mem,
  input  logic                         hold,
  input  logic [mem_cfg_pkg::XLEN-1:0] wb_res,
  output mem_stage_pkg::mem_wb_t       mem_wb
);

  // One request and one read byte per lane
  mem_stage_pkg::lane_req_t lane_req   [mem_cfg_pkg::LANES];
  logic [7:0]               lane_rdata [mem_cfg_pkg::LANES];

  //////////////////////////////
  // Store side
  //////////////////////////////

  // Forwarding looks at the instruction now in MEM/WB
  store_lane_unit store_i (
    .bus      (bus),
    .rst      (rst),
    .ex_mem   (ex_mem),
    .hold     (hold),
    .mem_wb   (mem_wb),
    .wb_res   (wb_res),
    .lane_req (lane_req)
  );

  //////////////////////////////
  // Data memory banks
  //////////////////////////////

  for (genvar i = 0; i < mem_cfg_pkg::LANES; i++) begin : g_bank
    data_bank bank_i (
      .bus   (bus),
      .req   (lane_req[i]),
      .rdata (lane_rdata[i])
    );
  end

  //////////////////////////////
  // Load and writeback side
  //////////////////////////////

  load_writeback_unit load_i (
    .bus        (bus),
    .rst        (rst),
    .ex_mem     (ex_mem),
    .hold       (hold),
    .lane_rdata (lane_rdata),
    .mem_wb     (mem_wb)
  );

endmodule : mem_stage

/* verification/clock_gen.sv */
module clock_gen (
  output logic bus,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  // 20 ns period
  localparam time HALF_PERIOD = 10ns;
  localparam int  RESET_CYCLES = 4;

  initial begin
    bus = 1'b0;
    forever #HALF_PERIOD bus = ~bus;
  end

  // Reset high from time zero, dropped on an edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus);
    rst <= 1'b0;
  end

endmodule : clock_gen

/* verification/mem_stage_tb.sv */
module mem_stage_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADDR_W      = mem_cfg_pkg::INDEX_W + 2;
  localparam int RESET_LIMIT = 20;
  localparam int DRAIN_LIMIT = 8;

  logic                         bus;
  logic                         rst;
  mem_stage_pkg::ex_mem_t       ex_mem;
  logic                         hold;
  logic [mem_cfg_pkg::XLEN-1:0] wb_res;
  mem_stage_pkg::mem_wb_t       mem_wb;

  // Byte-addressed reference memory, word index above the lane number
  logic [7:0] ref_mem [mem_cfg_pkg::DEPTH_WORDS * mem_cfg_pkg::LANES];

  // Instruction now sitting in MEM/WB, as the store side sees it
  logic                          prev_regwrite;
  logic [mem_cfg_pkg::REG_W-1:0] prev_rd;
  mem_stage_pkg::mem_wb_t        last_exp;

  // Expectation set with the request, then delayed one edge
  logic                   pend_chk;
  mem_stage_pkg::mem_wb_t pend_exp;
  logic                   chk_q;
  mem_stage_pkg::mem_wb_t exp_q;

  clock_gen clk_i (
    .bus (bus),
    .rst (rst)
  );

  mem_stage dut_i (
    .bus    (bus),
    .rst    (rst),
    .ex_mem (ex_mem),
    .hold   (hold),
    .wb_res (wb_res),
    .mem_wb (mem_wb)
  );

  always @(posedge bus) begin
    if (rst) begin
      chk_q <= 1'b0;
      exp_q <= '0;
    end else begin
      chk_q <= pend_chk;
      exp_q <= pend_exp;
    end
  end

  task automatic report_failure(input string msg);
    $display("TEST FAIL");
    $display("%s", msg);
    $fatal(1, "Stopped at first error");
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Pipeline register comes out of reset cleared
  a_reset_clear : assert property (@(posedge bus) $fell(rst) |-> (mem_wb == '0))
    else report_failure($sformatf("[ERROR] mem_wb expected 0x0 actual 0x%h",
                                  $sampled(mem_wb)));

  a_result : assert property (@(posedge bus) disable iff (rst)
    chk_q |-> (mem_wb.result == exp_q.result))
    else report_failure($sformatf("[ERROR] mem_wb.result expected 0x%h actual 0x%h",
                                  $sampled(exp_q.result), $sampled(mem_wb.result)));

  a_alu_res : assert property (@(posedge bus) disable iff (rst)
    chk_q |-> (mem_wb.alu_res == exp_q.alu_res))
    else report_failure($sformatf("[ERROR] mem_wb.alu_res expected 0x%h actual 0x%h",
                                  $sampled(exp_q.alu_res), $sampled(mem_wb.alu_res)));

  a_rd : assert property (@(posedge bus) disable iff (rst)
    chk_q |-> (mem_wb.rd == exp_q.rd))
    else report_failure($sformatf("[ERROR] mem_wb.rd expected 0x%h actual 0x%h",
                                  $sampled(exp_q.rd), $sampled(mem_wb.rd)));

  a_regwrite : assert property (@(posedge bus) disable iff (rst)
    chk_q |-> (mem_wb.regwrite == exp_q.regwrite))
    else report_failure($sformatf("[ERROR] mem_wb.regwrite expected 0x%h actual 0x%h",
                                  $sampled(exp_q.regwrite), $sampled(mem_wb.regwrite)));

  a_memread : assert property (@(posedge bus) disable iff (rst)
    chk_q |-> (mem_wb.memread == exp_q.memread))
    else report_failure($sformatf("[ERROR] mem_wb.memread expected 0x%h actual 0x%h",
                                  $sampled(exp_q.memread), $sampled(mem_wb.memread)));

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Byte k of an access lands in lane (offset + k) mod 4 of the same word
  function automatic logic [ADDR_W-1:0] lane_addr(input logic [31:0] addr, input int k);
    return {addr[ADDR_W-1:2], 2'(addr[1:0] + 2'(k))};
  endfunction

  task automatic model_step(input mem_stage_pkg::ex_mem_t e, input logic [31:0] wbr,
                            output mem_stage_pkg::mem_wb_t exp);
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] word;
    int          nbytes;
    int          k;
    addr = e.alu_res;
    // Full words ignore the byte offset
    if (e.op inside {mem_stage_pkg::MEM_SW, mem_stage_pkg::MEM_LW}) begin
      addr[1:0] = 2'b00;
    end
    data = e.rs2_data;
    if ((e.op inside {mem_stage_pkg::MEM_SB, mem_stage_pkg::MEM_SH, mem_stage_pkg::MEM_SW})
        && prev_regwrite && (prev_rd != '0) && (prev_rd == e.rs2_num)) begin
      data = wbr;
    end
    nbytes = (e.op == mem_stage_pkg::MEM_SB) ? 1 :
             (e.op == mem_stage_pkg::MEM_SH) ? 2 :
             (e.op == mem_stage_pkg::MEM_SW) ? 4 : 0;
    for (k = 0; k < nbytes; k++) begin
      ref_mem[lane_addr(addr, k)] = data[8*k +: 8];
    end
    for (k = 0; k < 4; k++) begin
      word[8*k +: 8] = ref_mem[lane_addr(addr, k)];
    end
    exp.regwrite = e.regwrite;
    exp.rd       = e.rd;
    exp.alu_res  = e.alu_res;
    exp.memread  = 1'b1;
    case (e.op)
      mem_stage_pkg::MEM_LB:  exp.result = {{24{word[7]}}, word[7:0]};
      mem_stage_pkg::MEM_LH:  exp.result = {{16{word[15]}}, word[15:0]};
      mem_stage_pkg::MEM_LW:  exp.result = word;
      mem_stage_pkg::MEM_LBU: exp.result = {24'd0, word[7:0]};
      mem_stage_pkg::MEM_LHU: exp.result = {16'd0, word[15:0]};
      default: begin
        exp.memread = 1'b0;
        exp.result  = e.alu_res;
      end
    endcase
    prev_regwrite = e.regwrite;
    prev_rd       = e.rd;
    last_exp      = exp;
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  function automatic mem_stage_pkg::ex_mem_t random_instr(input mem_stage_pkg::mem_op_e op);
    mem_stage_pkg::ex_mem_t e;
    e.op       = op;
    e.alu_res  = $urandom;
    e.rs2_num  = 5'($urandom);
    e.rs2_data = $urandom;
    e.rd       = 5'($urandom);
    e.regwrite = 1'($urandom);
    return e;
  endfunction

  // Held requests expect MEM/WB to keep the last result
  task automatic issue(input mem_stage_pkg::ex_mem_t e, input logic h, input logic [31:0] wbr);
    mem_stage_pkg::mem_wb_t exp;
    @(posedge bus);
    ex_mem <= e;
    hold   <= h;
    wb_res <= wbr;
    if (h) begin
      exp = last_exp;
    end else begin
      model_step(e, wbr, exp);
    end
    pend_chk <= 1'b1;
    pend_exp <= exp;
  endtask

  task automatic load_at(input logic [31:0] addr, input mem_stage_pkg::mem_op_e op);
    mem_stage_pkg::ex_mem_t e;
    e         = random_instr(op);
    e.alu_res = addr;
    issue(e, 1'b0, $urandom);
  endtask

  task automatic word_round_trips(input int count);
    mem_stage_pkg::ex_mem_t e;
    int                     i;
    for (i = 0; i < count; i++) begin
      e = random_instr(mem_stage_pkg::MEM_SW);
      issue(e, 1'b0, $urandom);
      load_at(e.alu_res, mem_stage_pkg::MEM_LW);
      // Plain ALU op writes back its own result
      issue(random_instr(mem_stage_pkg::MEM_NONE), 1'b0, $urandom);
    end
  endtask

  task automatic sub_word_merges();
    mem_stage_pkg::ex_mem_t base;
    mem_stage_pkg::ex_mem_t e;
    int                     off;
    for (off = 0; off < 4; off++) begin
      base = random_instr(mem_stage_pkg::MEM_SW);
      base.alu_res[1:0] = 2'b00;
      issue(base, 1'b0, $urandom);
      e = random_instr(mem_stage_pkg::MEM_SB);
      e.alu_res = base.alu_res | 32'(off);
      issue(e, 1'b0, $urandom);
      load_at(base.alu_res, mem_stage_pkg::MEM_LW);
      load_at(e.alu_res, mem_stage_pkg::MEM_LB);
      load_at(e.alu_res, mem_stage_pkg::MEM_LBU);
      // Offset 3 wraps the upper byte into lane 0
      e.op = mem_stage_pkg::MEM_SH;
      e.rs2_data = $urandom;
      issue(e, 1'b0, $urandom);
      load_at(base.alu_res, mem_stage_pkg::MEM_LW);
      load_at(e.alu_res, mem_stage_pkg::MEM_LH);
      load_at(e.alu_res, mem_stage_pkg::MEM_LHU);
    end
  endtask

  task automatic store_forwarding(input logic [4:0] reg_num);
    mem_stage_pkg::ex_mem_t e;
    logic [31:0]            addr;
    addr = $urandom;
    // Producer of reg_num, then a store reading it straight away
    e          = random_instr(mem_stage_pkg::MEM_NONE);
    e.rd       = reg_num;
    e.regwrite = 1'b1;
    issue(e, 1'b0, $urandom);
    e         = random_instr(mem_stage_pkg::MEM_SW);
    e.alu_res = addr;
    e.rs2_num = reg_num;
    issue(e, 1'b0, $urandom);
    load_at(addr, mem_stage_pkg::MEM_LW);
  endtask

  task automatic frozen_store(input int cycles);
    mem_stage_pkg::ex_mem_t e;
    int                     i;
    e = random_instr(mem_stage_pkg::MEM_SW);
    issue(e, 1'b0, $urandom);
    // Different data presented while frozen must never land
    e.rs2_data = ~e.rs2_data;
    e.rs2_num  = 5'd0;
    // MEM/WB fields of the frozen store differ too
    // Only the byte offset moves so the word stays the same
    e.alu_res[1:0] = ~e.alu_res[1:0];
    e.rd           = ~e.rd;
    e.regwrite     = ~e.regwrite;
    for (i = 0; i < cycles; i++) begin
      issue(e, 1'b1, $urandom);
    end
    load_at(e.alu_res, mem_stage_pkg::MEM_LW);
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (rst) begin
      @(posedge bus);
      cnt++;
      if (cnt > RESET_LIMIT) begin
        report_failure("Timeout: reset was never released");
      end
    end
  endtask

  // Idle the stage until the last expectation has been compared
  task automatic drain_checks();
    int cnt;
    @(posedge bus);
    ex_mem   <= '0;
    hold     <= 1'b0;
    pend_chk <= 1'b0;
    cnt = 0;
    do begin
      @(posedge bus);
      cnt++;
      if (cnt > DRAIN_LIMIT) begin
        report_failure("Timeout: pending checks did not drain");
      end
    end while (chk_q);
  endtask

  initial begin
    void'($urandom(34));
    ex_mem        = '0;
    hold          = 1'b0;
    wb_res        = '0;
    pend_chk      = 1'b0;
    pend_exp      = '0;
    last_exp      = '0;
    prev_regwrite = 1'b0;
    prev_rd       = '0;
    wait_reset_release();
    word_round_trips(8);
    sub_word_merges();
    store_forwarding(5'd7);
    // x0 never forwards
    store_forwarding(5'd0);
    frozen_store(5);
    drain_checks();
    $display("TEST PASS");
    $finish;
  end

endmodule : mem_stage_tb

/* list.f */
source/mem_cfg_pkg.sv
source/mem_stage_pkg.sv
source/store_lane_unit.sv
source/data_bank.sv
source/load_writeback_unit.sv
source/mem_stage.sv
verification/clock_gen.sv
verification/mem_stage_tb.sv

/* Makefile */
# Verilator flow for the memory-access stage

VERILATOR ?= verilator
TOP       ?= mem_stage_tb
RTL_TOP   ?= mem_stage
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= TEST PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

# Pass only when the pass line appears in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
